/* src/copy_engine_pkg.sv */
// shared word and buffer constants for the copy engine
// vector typedefs for words, bytes, byte enables and counts
// writer state enum
`default_nettype none

package copy_engine_pkg;

    localparam int WORD_BYTES = 4;  // bytes per memory word
    localparam int BUF_BYTES  = 8;  // alignment buffer capacity

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [3:0]  bwe_t;
    typedef logic [1:0]  shift_t;    // byte offset within a word
    typedef logic [3:0]  buf_cnt_t;  // 0..8 bytes

    // destination word phases
    typedef enum logic [1:0] {
        WR_IDLE,
        WR_FIRST,
        WR_MIDDLE,
        WR_LAST
    } wr_state_e;

endpackage

`default_nettype wire

/* src/cmd_reception.sv */
// command acceptance and parameter latch
// one-cycle start pulse, done flag
`timescale 1ns/100ps
`default_nettype none

module cmd_reception import copy_engine_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int LEN_WIDTH  = 16
) (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   copy_i,
    input  wire                   set_i,
    input  wire byte_t            set_val_i,
    input  wire [LEN_WIDTH-1:0]   len_i,
    input  wire [ADDR_WIDTH-1:0]  src_i,
    input  wire [ADDR_WIDTH-1:0]  dst_i,
    input  wire                   rd_busy_i,
    input  wire                   wr_busy_i,
    output logic                  start_o,
    output logic                  op_copy_o,
    output logic [ADDR_WIDTH-1:0] src_o,
    output logic [ADDR_WIDTH-1:0] dst_o,
    output logic [LEN_WIDTH-1:0]  len_o,
    output byte_t                 set_val_o,
    output logic                  done_o
);

    logic accept;

    // pending start keeps done low until the pipelines report busy
    assign done_o = ~start_o & ~rd_busy_i & ~wr_busy_i;
    assign accept = done_o & (copy_i | set_i);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            start_o <= 1'b0;
        end else begin
            start_o <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            op_copy_o <= copy_i;  // copy wins over fill
            src_o     <= src_i;
            dst_o     <= dst_i;
            len_o     <= len_i;
            set_val_o <= set_val_i;
        end
    end

endmodule

`default_nettype wire

/* src/mem_reader.sv */
// source read pipeline
// word read requests held until accepted, remaining byte count, FIFO slot reservation
`timescale 1ns/100ps
`default_nettype none

module mem_reader import copy_engine_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int LEN_WIDTH  = 16
) (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   start_i,
    input  wire                   op_copy_i,
    input  wire [ADDR_WIDTH-1:0]  src_i,
    input  wire [LEN_WIDTH-1:0]   len_i,
    input  wire                   fifo_wrdy_i,
    input  wire                   mem_rreq_rdy_i,
    output logic                  mem_re_o,
    output logic [ADDR_WIDTH-1:0] mem_rad_o,
    output logic                  reserve_o,
    output logic                  rd_busy_o
);

    logic [ADDR_WIDTH-1:0] word_ptr;  // next word to request
    logic [LEN_WIDTH-1:0]  cnt, cnt_nxt;
    logic                  first;
    shift_t                src_ofs;
    buf_cnt_t              rd_num;
    logic                  accept, issue;

    // first word loses the source offset
    assign rd_num    = first ? buf_cnt_t'(WORD_BYTES - int'(src_ofs)) : buf_cnt_t'(WORD_BYTES);
    assign accept    = mem_re_o & mem_rreq_rdy_i;
    assign reserve_o = accept;
    assign rd_busy_o = (cnt != '0) | mem_re_o;

    always_comb begin
        cnt_nxt = cnt;
        if (accept) begin
            cnt_nxt = (cnt > LEN_WIDTH'(rd_num)) ? cnt - LEN_WIDTH'(rd_num) : '0;
        end
    end

    assign issue = (cnt_nxt != '0) && fifo_wrdy_i && (!mem_re_o || mem_rreq_rdy_i);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            mem_re_o  <= 1'b0;
            mem_rad_o <= '0;
            word_ptr  <= '0;
            cnt       <= '0;
            first     <= 1'b0;
        end else if (start_i && op_copy_i) begin
            // fill commands leave the reader idle
            cnt       <= len_i;
            first     <= 1'b1;
            mem_re_o  <= 1'b1;
            mem_rad_o <= {2'b00, src_i[ADDR_WIDTH-1:2]};
            word_ptr  <= {2'b00, src_i[ADDR_WIDTH-1:2]} + 1'b1;
        end else begin
            cnt <= cnt_nxt;
            if (accept) first <= 1'b0;
            if (issue) begin
                mem_re_o  <= 1'b1;
                mem_rad_o <= word_ptr;
                word_ptr  <= word_ptr + 1'b1;
            end else if (mem_rreq_rdy_i) begin
                mem_re_o <= 1'b0;  // request taken, nothing new
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) src_ofs <= src_i[1:0];
    end

endmodule

`default_nettype wire

/* src/reserve_fifo.sv */
// read data FIFO with slot reservation
// write readiness counts reserved slots, so returned data always has room
`timescale 1ns/100ps
`default_nettype none

module reserve_fifo import copy_engine_pkg::*; #(
    parameter int AW = 3
) (
    input  wire        clk,
    input  wire        rstn,
    input  wire        reserve_i,
    input  wire        wr_en_i,
    input  wire word_t din_i,
    input  wire        rd_en_i,
    output word_t      dout_o,
    output logic       wrdy_o,
    output logic       rrdy_o
);

    localparam int          DEPTH   = 1 << AW;
    localparam logic [AW:0] RSV_MAX = (AW + 1)'(DEPTH - 1);

    word_t         mem [DEPTH];
    logic [AW-1:0] wptr, rptr;
    logic [AW:0]   fill_cnt;  // words stored
    logic [AW:0]   rsv_cnt;   // words reserved, stored ones included

    // one spare slot covers a request issued while the last one is accepted
    assign wrdy_o = rsv_cnt < RSV_MAX;
    assign rrdy_o = fill_cnt != '0;
    assign dout_o = mem[rptr];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wptr     <= '0;
            rptr     <= '0;
            fill_cnt <= '0;
            rsv_cnt  <= '0;
        end else begin
            if (wr_en_i) wptr <= wptr + 1'b1;
            if (rd_en_i) rptr <= rptr + 1'b1;
            fill_cnt <= fill_cnt + {{AW{1'b0}}, wr_en_i} - {{AW{1'b0}}, rd_en_i};
            rsv_cnt  <= rsv_cnt + {{AW{1'b0}}, reserve_i} - {{AW{1'b0}}, rd_en_i};
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en_i) mem[wptr] <= din_i;
    end

endmodule

`default_nettype wire

/* src/align_buffer.sv */
// eight-byte alignment buffer
// loads source words from the FIFO or fill bytes, drained by the writer
`timescale 1ns/100ps
`default_nettype none

module align_buffer import copy_engine_pkg::*; #(
    parameter int LEN_WIDTH = 16
) (
    input  wire                  clk,
    input  wire                  rstn,
    input  wire                  start_i,
    input  wire                  op_copy_i,
    input  wire shift_t          src_i,
    input  wire [LEN_WIDTH-1:0]  len_i,
    input  wire byte_t           set_val_i,
    input  wire                  fifo_rrdy_i,
    input  wire word_t           fifo_rdat_i,
    input  wire                  pop_i,
    input  wire buf_cnt_t        pop_num_i,
    output logic                 fifo_re_o,
    output word_t                buf_data_o,
    output buf_cnt_t             buf_bytes_o
);

    logic [8*BUF_BYTES-1:0] buf_q, buf_nxt, ins;
    buf_cnt_t               cnt, kept_cnt, word_num, ld_num;
    logic [LEN_WIDTH-1:0]   ld_rem;  // bytes still to load
    logic                   first, is_copy, load;
    shift_t                 src_ofs;
    byte_t                  fill_val;
    word_t                  src_word;

    assign buf_data_o  = buf_q[31:0];  // byte 0 is the oldest
    assign buf_bytes_o = cnt;
    assign kept_cnt    = cnt - (pop_i ? pop_num_i : '0);

    assign word_num = first ? buf_cnt_t'(WORD_BYTES - int'(src_ofs)) : buf_cnt_t'(WORD_BYTES);
    assign src_word = first ? word_t'(fifo_rdat_i >> (8 * int'(src_ofs))) : fifo_rdat_i;

    always_comb begin
        ld_num = '0;
        ins    = '0;
        load   = 1'b0;
        if (is_copy) begin
            ld_num = (ld_rem < LEN_WIDTH'(word_num)) ? buf_cnt_t'(ld_rem) : word_num;
            // fit check on the count before the pop keeps this off the writer path
            load   = fifo_rrdy_i && (ld_rem != '0) &&
                     ((cnt + ld_num) <= buf_cnt_t'(BUF_BYTES));
            ins    = {32'b0, src_word} << (8 * int'(kept_cnt));
        end else begin
            ld_num = (ld_rem < LEN_WIDTH'(BUF_BYTES - int'(cnt))) ?
                     buf_cnt_t'(ld_rem) : buf_cnt_t'(BUF_BYTES - int'(cnt));
            load   = (ld_rem != '0) && (cnt != buf_cnt_t'(BUF_BYTES));
            ins    = {BUF_BYTES{fill_val}};
        end
    end

    assign fifo_re_o = is_copy & load;

    // shift out popped bytes, then place new bytes above the kept ones
    always_comb begin
        buf_nxt = pop_i ? buf_q >> (8 * int'(pop_num_i)) : buf_q;
        if (load) begin
            for (int i = 0; i < BUF_BYTES; i++) begin
                if (buf_cnt_t'(i) >= kept_cnt) buf_nxt[8*i +: 8] = ins[8*i +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cnt     <= '0;
            ld_rem  <= '0;
            first   <= 1'b0;
            is_copy <= 1'b0;
        end else if (start_i) begin
            cnt     <= '0;
            ld_rem  <= len_i;
            first   <= 1'b1;
            is_copy <= op_copy_i;
        end else begin
            cnt <= kept_cnt + (load ? ld_num : '0);
            if (load) begin
                ld_rem <= ld_rem - LEN_WIDTH'(ld_num);
                first  <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        buf_q <= buf_nxt;
        if (start_i) begin
            src_ofs  <= src_i;
            fill_val <= set_val_i;
        end
    end

endmodule

`default_nettype wire

/* src/mem_writer.sv */
// destination write FSM
// per-word byte count, byte enables, shifted write data, held write request
`timescale 1ns/100ps
`default_nettype none

module mem_writer import copy_engine_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int LEN_WIDTH  = 16
) (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   start_i,
    input  wire [ADDR_WIDTH-1:0]  dst_i,
    input  wire [LEN_WIDTH-1:0]   len_i,
    input  wire word_t            buf_data_i,
    input  wire buf_cnt_t         buf_bytes_i,
    input  wire                   mem_wreq_rdy_i,
    output logic                  pop_o,
    output buf_cnt_t              pop_num_o,
    output logic                  mem_we_o,
    output bwe_t                  mem_bwe_o,
    output logic [ADDR_WIDTH-1:0] mem_wad_o,
    output word_t                 mem_wdat_o,
    output logic                  wr_busy_o
);

    wr_state_e             state, state_nxt;
    logic [ADDR_WIDTH-1:0] word_ptr;
    logic [LEN_WIDTH-1:0]  rem, rem_nxt;
    shift_t                dst_ofs;
    buf_cnt_t              num, first_room;
    bwe_t                  mask;
    logic                  issue;

    assign first_room = buf_cnt_t'(WORD_BYTES - int'(dst_ofs));

    always_comb begin
        case (state)
            WR_FIRST: num = (rem < LEN_WIDTH'(first_room)) ? buf_cnt_t'(rem) : first_room;
            WR_LAST:  num = buf_cnt_t'(rem);
            default:  num = buf_cnt_t'(WORD_BYTES);
        endcase
    end

    // output slot free or being taken, and enough bytes buffered
    assign issue     = (state != WR_IDLE) && (!mem_we_o || mem_wreq_rdy_i) &&
                       (buf_bytes_i >= num);
    assign pop_o     = issue;
    assign pop_num_o = num;
    assign mask      = bwe_t'(~(8'hff << num));  // low num bytes
    assign rem_nxt   = rem - LEN_WIDTH'(num);
    assign wr_busy_o = (state != WR_IDLE) | mem_we_o;

    always_comb begin
        if (rem_nxt == '0)                          state_nxt = WR_IDLE;
        else if (rem_nxt <= LEN_WIDTH'(WORD_BYTES)) state_nxt = WR_LAST;
        else                                        state_nxt = WR_MIDDLE;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state     <= WR_IDLE;
            rem       <= '0;
            mem_we_o  <= 1'b0;
            mem_bwe_o <= '0;
        end else if (start_i) begin
            state <= WR_FIRST;
            rem   <= len_i;
        end else if (issue) begin
            state     <= state_nxt;
            rem       <= rem_nxt;
            mem_we_o  <= 1'b1;
            mem_bwe_o <= (state == WR_FIRST) ? bwe_t'(mask << dst_ofs) : mask;
        end else if (mem_wreq_rdy_i) begin
            mem_we_o  <= 1'b0;
            mem_bwe_o <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (start_i) begin
            dst_ofs  <= dst_i[1:0];
            word_ptr <= {2'b00, dst_i[ADDR_WIDTH-1:2]};
        end else if (issue) begin
            mem_wad_o  <= word_ptr;
            mem_wdat_o <= (state == WR_FIRST) ? word_t'(buf_data_i << (8 * int'(dst_ofs))) :
                                                buf_data_i;
            word_ptr   <= word_ptr + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/copy_engine.sv */
// copy engine top level
// command stage, source reader, read FIFO, alignment buffer, destination writer
`timescale 1ns/100ps
`default_nettype none

module copy_engine import copy_engine_pkg::*; #(
    parameter int ADDR_WIDTH = 32,
    parameter int LEN_WIDTH  = 16,
    parameter int RD_FIFO_AW = 3
) (
    input  wire                   clk,
    input  wire                   rstn,
    input  wire                   copy_i,
    input  wire                   set_i,
    input  wire byte_t            set_val_i,
    input  wire [LEN_WIDTH-1:0]   len_i,
    input  wire [ADDR_WIDTH-1:0]  src_i,
    input  wire [ADDR_WIDTH-1:0]  dst_i,
    output logic                  done_o,
    output logic                  mem_re_o,
    output logic [ADDR_WIDTH-1:0] mem_rad_o,
    input  wire                   mem_rreq_rdy_i,
    input  wire word_t            mem_rdat_i,
    input  wire                   mem_rdat_rdy_i,
    output logic                  mem_we_o,
    output bwe_t                  mem_bwe_o,
    output logic [ADDR_WIDTH-1:0] mem_wad_o,
    output word_t                 mem_wdat_o,
    input  wire                   mem_wreq_rdy_i
);

    logic                  start, op_copy;
    logic [ADDR_WIDTH-1:0] src, dst;
    logic [LEN_WIDTH-1:0]  len;
    byte_t                 set_val;
    logic                  rd_busy, wr_busy;
    logic                  reserve, fifo_wrdy, fifo_rrdy, fifo_re;
    word_t                 fifo_rdat, buf_data;
    buf_cnt_t              buf_bytes, pop_num;
    logic                  pop;

    cmd_reception #(.ADDR_WIDTH(ADDR_WIDTH), .LEN_WIDTH(LEN_WIDTH)) u_cmd (
        .clk(clk), .rstn(rstn),
        .copy_i(copy_i), .set_i(set_i), .set_val_i(set_val_i),
        .len_i(len_i), .src_i(src_i), .dst_i(dst_i),
        .rd_busy_i(rd_busy), .wr_busy_i(wr_busy),
        .start_o(start), .op_copy_o(op_copy), .src_o(src), .dst_o(dst),
        .len_o(len), .set_val_o(set_val), .done_o(done_o)
    );

    mem_reader #(.ADDR_WIDTH(ADDR_WIDTH), .LEN_WIDTH(LEN_WIDTH)) u_reader (
        .clk(clk), .rstn(rstn),
        .start_i(start), .op_copy_i(op_copy), .src_i(src), .len_i(len),
        .fifo_wrdy_i(fifo_wrdy), .mem_rreq_rdy_i(mem_rreq_rdy_i),
        .mem_re_o(mem_re_o), .mem_rad_o(mem_rad_o),
        .reserve_o(reserve), .rd_busy_o(rd_busy)
    );

    reserve_fifo #(.AW(RD_FIFO_AW)) u_rdfifo (
        .clk(clk), .rstn(rstn),
        .reserve_i(reserve), .wr_en_i(mem_rdat_rdy_i), .din_i(mem_rdat_i),
        .rd_en_i(fifo_re),
        .dout_o(fifo_rdat), .wrdy_o(fifo_wrdy), .rrdy_o(fifo_rrdy)
    );

    align_buffer #(.LEN_WIDTH(LEN_WIDTH)) u_align (
        .clk(clk), .rstn(rstn),
        .start_i(start), .op_copy_i(op_copy), .src_i(src[1:0]), .len_i(len),
        .set_val_i(set_val), .fifo_rrdy_i(fifo_rrdy), .fifo_rdat_i(fifo_rdat),
        .pop_i(pop), .pop_num_i(pop_num),
        .fifo_re_o(fifo_re), .buf_data_o(buf_data), .buf_bytes_o(buf_bytes)
    );

    mem_writer #(.ADDR_WIDTH(ADDR_WIDTH), .LEN_WIDTH(LEN_WIDTH)) u_writer (
        .clk(clk), .rstn(rstn),
        .start_i(start), .dst_i(dst), .len_i(len),
        .buf_data_i(buf_data), .buf_bytes_i(buf_bytes),
        .mem_wreq_rdy_i(mem_wreq_rdy_i),
        .pop_o(pop), .pop_num_o(pop_num),
        .mem_we_o(mem_we_o), .mem_bwe_o(mem_bwe_o), .mem_wad_o(mem_wad_o),
        .mem_wdat_o(mem_wdat_o), .wr_busy_o(wr_busy)
    );

endmodule

`default_nettype wire

/* tests/tb_mem_model.sv */
// byte-addressed memory model for the copy engine testbench
// random request stalls, in-order read return 1 to 4 cycles after acceptance
`timescale 1ns/100ps
`default_nettype none

module tb_mem_model import copy_engine_pkg::*; #(
    parameter int MEM_BYTES = 4096,
    parameter int DST_BASE  = 'h800,  // destination region starts here
    parameter int SEED      = 32'h7c89
) (
    input  wire         clk,
    input  wire         re_i,
    input  wire [31:0]  rad_i,
    output logic        rreq_rdy_o,
    output word_t       rdat_o,
    output logic        rdat_rdy_o,
    input  wire         we_i,
    input  wire bwe_t   bwe_i,
    input  wire [31:0]  wad_i,
    input  wire word_t  wdat_i,
    output logic        wreq_rdy_o
);

    logic [7:0] mem [MEM_BYTES];
    word_t      rd_q[$];   // words waiting to return
    int         due_q[$];  // cycle each one returns

    initial begin
        int cycle;
        int last_due;
        int due;
        int base;
        cycle    = 0;
        last_due = 0;
        void'($urandom(SEED));
        // source bytes follow the address, destination starts as 0xee
        for (int a = 0; a < MEM_BYTES; a++) begin
            mem[a] = (a < DST_BASE) ? (8'(a) ^ 8'h5a) : 8'hee;
        end
        rreq_rdy_o <= 1'b0;
        wreq_rdy_o <= 1'b0;
        rdat_rdy_o <= 1'b0;
        rdat_o     <= '0;
        forever begin
            @(posedge clk);
            cycle++;
            if (re_i && rreq_rdy_o) begin
                base = int'(rad_i[9:0]) * WORD_BYTES;
                due  = cycle + 1 + int'($urandom % 4);
                if (due <= last_due) due = last_due + 1;  // keep return order
                last_due = due;
                rd_q.push_back({mem[base+3], mem[base+2], mem[base+1], mem[base]});
                due_q.push_back(due);
            end
            if (we_i && wreq_rdy_o) begin
                base = int'(wad_i[9:0]) * WORD_BYTES;
                for (int b = 0; b < WORD_BYTES; b++) begin
                    if (bwe_i[b]) mem[base+b] = wdat_i[8*b +: 8];
                end
            end
            if (due_q.size() > 0 && due_q[0] <= cycle) begin
                rdat_o     <= rd_q.pop_front();
                rdat_rdy_o <= 1'b1;
                void'(due_q.pop_front());
            end else begin
                rdat_rdy_o <= 1'b0;
            end
            rreq_rdy_o <= ($urandom % 4) != 0;  // stall about one cycle in four
            wreq_rdy_o <= ($urandom % 4) != 0;
        end
    end

endmodule

`default_nettype wire

/* tests/copy_engine_tb.sv */
// copy engine testbench top
// reads tests from the test data file, runs them back to back
// checks destination bytes and guard bytes, watchdog
`timescale 1ns/100ps
`default_nettype none

module copy_engine_tb import copy_engine_pkg::*; ();

    localparam string DATA_FILE = "tests/copy_engine_testdata.txt";
    localparam int    DST_BASE  = 'h800;  // sources below, destinations from here

    logic        clk, rstn;
    logic        cmd_copy, cmd_set;
    byte_t       cmd_val;
    logic [15:0] cmd_len;
    logic [31:0] cmd_src, cmd_dst;
    logic        done;
    logic        mem_re, mem_rreq_rdy, mem_rdat_rdy, mem_we, mem_wreq_rdy;
    logic [31:0] mem_rad, mem_wad;
    word_t       mem_rdat, mem_wdat;
    bwe_t        mem_bwe;

    string names[$];
    bit    is_copy[$];
    int    srcs[$], dsts[$], lens[$], vals[$];
    int    err_cnt;  // mismatches in the running test
    int    pass_cnt, fail_cnt;
    int    budget;   // watchdog limit in cycles
    logic  loaded;

    always #4 clk = ~clk;

    copy_engine #(.ADDR_WIDTH(32), .LEN_WIDTH(16), .RD_FIFO_AW(3)) uut (
        .clk(clk), .rstn(rstn),
        .copy_i(cmd_copy), .set_i(cmd_set), .set_val_i(cmd_val),
        .len_i(cmd_len), .src_i(cmd_src), .dst_i(cmd_dst), .done_o(done),
        .mem_re_o(mem_re), .mem_rad_o(mem_rad), .mem_rreq_rdy_i(mem_rreq_rdy),
        .mem_rdat_i(mem_rdat), .mem_rdat_rdy_i(mem_rdat_rdy),
        .mem_we_o(mem_we), .mem_bwe_o(mem_bwe), .mem_wad_o(mem_wad),
        .mem_wdat_o(mem_wdat), .mem_wreq_rdy_i(mem_wreq_rdy)
    );

    tb_mem_model #(.DST_BASE(DST_BASE), .SEED(32'h7c89)) u_mem (
        .clk(clk),
        .re_i(mem_re), .rad_i(mem_rad), .rreq_rdy_o(mem_rreq_rdy),
        .rdat_o(mem_rdat), .rdat_rdy_o(mem_rdat_rdy),
        .we_i(mem_we), .bwe_i(mem_bwe), .wad_i(mem_wad), .wdat_i(mem_wdat),
        .wreq_rdy_o(mem_wreq_rdy)
    );

    // memory content before any test
    function automatic byte_t initial_byte(int a);
        return (a < DST_BASE) ? (byte_t'(a) ^ 8'h5a) : 8'hee;
    endfunction

    // byte a of memory once test t has run
    function automatic byte_t expected_byte(int t, int a);
        if (a < dsts[t] || a >= dsts[t] + lens[t]) return initial_byte(a);  // untouched
        if (!is_copy[t]) return byte_t'(vals[t]);
        return initial_byte(srcs[t] + (a - dsts[t]));
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (exp !== act) begin
            $display("FAILED %s: expected %0h, actual %0h", what, exp, act);
            err_cnt++;
        end
    endtask

    task automatic load_tests(output bit ok);
        int    fd;
        int    s, d, l, v;
        string line, name, op;
        fd = $fopen(DATA_FILE, "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() < 2 || line[0] == "#") continue;  // header, blank
                if ($sscanf(line, "%s %s %h %h %d %h", name, op, s, d, l, v) == 6) begin
                    names.push_back(name);
                    is_copy.push_back(op == "copy");
                    srcs.push_back(s);
                    dsts.push_back(d);
                    lens.push_back(l);
                    vals.push_back(v);
                end
            end
            $fclose(fd);
        end
        ok = names.size() > 0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done) @(negedge clk);
    endtask

    // idle outputs straight after reset
    task automatic verify_reset_outputs();
        err_cnt = 0;
        @(negedge clk);
        check_value("reset done", 1, done);
        check_value("reset mem_re", 0, mem_re);
        check_value("reset mem_we", 0, mem_we);
        check_value("reset mem_bwe", 0, mem_bwe);
        if (err_cnt == 0) pass_cnt++;
        else fail_cnt++;
        $display("test %-14s %s, %0d mismatches", "reset_values",
                 (err_cnt == 0) ? "ok" : "bad", err_cnt);
    endtask

    task automatic run_test(input int t);
        err_cnt = 0;
        wait_done();
        @(posedge clk);
        cmd_copy <= is_copy[t];
        cmd_set  <= !is_copy[t];
        cmd_src  <= srcs[t];
        cmd_dst  <= dsts[t];
        cmd_len  <= 16'(lens[t]);
        cmd_val  <= byte_t'(vals[t]);
        @(posedge clk);  // taken on this edge
        cmd_copy <= 1'b0;
        cmd_set  <= 1'b0;
        @(negedge clk);
        check_value({names[t], " done while busy"}, 0, done);
        wait_done();
        for (int a = dsts[t] - 4; a < dsts[t] + lens[t] + 4; a++) begin
            check_value($sformatf("%s byte %0h", names[t], a), expected_byte(t, a),
                        u_mem.mem[a]);
        end
        if (err_cnt == 0) pass_cnt++;
        else fail_cnt++;
        $display("test %-14s %s, %0d mismatches", names[t],
                 (err_cnt == 0) ? "ok" : "bad", err_cnt);
    endtask

    initial begin : watchdog
        wait (loaded);
        repeat (budget) @(posedge clk);
        $display("run timed out after %0d cycles with tests still running", budget);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin : main
        bit ok;
        clk      = 1'b0;
        rstn     = 1'b0;
        loaded   = 1'b0;
        cmd_copy = 1'b0;
        cmd_set  = 1'b0;
        cmd_val  = '0;
        cmd_len  = '0;
        cmd_src  = '0;
        cmd_dst  = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        budget   = 20;  // reset and margin
        load_tests(ok);
        if (!ok) begin
            $display("no test could be read from %s", DATA_FILE);
            $display("Simulation finished: FAIL");
        end else begin
            foreach (lens[t]) budget += 200 + 20 * lens[t];
            loaded = 1'b1;
            repeat (5) @(posedge clk);
            rstn <= 1'b1;
            verify_reset_outputs();
            foreach (names[t]) run_test(t);
            $display("tests run %0d, passed %0d, failed %0d",
                     pass_cnt + fail_cnt, pass_cnt, fail_cnt);
            if (fail_cnt == 0) begin
                $display("Simulation finished: PASS");
            end else begin
                $display("Simulation finished: FAIL");
            end
        end
        $finish;
    end

endmodule

`default_nettype wire

/* copy_engine.f */
src/copy_engine_pkg.sv
src/cmd_reception.sv
src/mem_reader.sv
src/reserve_fifo.sv
src/align_buffer.sv
src/mem_writer.sv
src/copy_engine.sv
tests/tb_mem_model.sv
tests/copy_engine_tb.sv

/* Makefile */
# Verilator build and run of the copy engine testbench
TOP = copy_engine_tb

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): copy_engine.f $(wildcard src/*.sv tests/*.sv)
	verilator --binary --timing --timescale 1ns/100ps -j 0 \
		--top-module $(TOP) -f copy_engine.f

# the log decides pass or fail
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation finished: PASS" sim.log

lint:
	verilator --lint-only -Wall --timing --timescale 1ns/100ps \
		--top-module $(TOP) -f copy_engine.f

clean:
	rm -rf obj_dir sim.log

/* tests/copy_engine_testdata.txt */
# name  op(copy|fill)  src(hex)  dst(hex)  len(dec)  fill value(hex)
# sources below 0x800 hold addr^0x5a, destinations from 0x800 start as 0xee
aligned_copy   copy 010 800 32  00
offset_copy    copy 021 843 23  00
short_copy1    copy 032 881 1   00
short_copy2    copy 047 8a1 2   00
short_copy3    copy 053 8c2 2   00
unaligned_fill fill 000 903 21  a5
fill_long      fill 000 941 40  3c
long_copy      copy 102 a01 200 00
offset_copy2   copy 203 b00 37  00
offset_copy3   copy 300 b62 15  00
fill_short     fill 000 bc3 1   77
copy_len3      copy 311 c02 3   00
long_copy2     copy 402 d03 150 00
fill_aligned   fill 000 e40 64  c3
